// ==== design/exu_config.svh ====
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// datapath and address width
`define EXU_XLEN 64

// machine mode CSR addresses
`define EXU_CSR_MTVEC    12'h305
`define EXU_CSR_MSCRATCH 12'h340
`define EXU_CSR_MEPC     12'h341
`define EXU_CSR_MCAUSE   12'h342

// mcause for environment call from M-mode
`define EXU_CAUSE_ECALL 11

`endif

// ==== design/exu_pkg.sv ====
`default_nettype none
`include "exu_config.svh"

package exu_pkg;

  typedef enum logic [3:0] {
    OP_ALU,
    OP_BRANCH,
    OP_JAL,
    OP_JALR,
    OP_LOAD,
    OP_STORE,
    OP_CSRRW,
    OP_CSRRS,
    OP_CSRRC,
    OP_ECALL,
    OP_MRET,
    OP_EBREAK
  } op_class_t;

  // branches reuse these: SUB for beq, XOR for bne, compares for the rest
  typedef enum logic [3:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    SGE,
    SGEU
  } alu_op_t;

  typedef struct packed {
    op_class_t            op;
    alu_op_t              alu_op;
    logic [`EXU_XLEN-1:0] src1;
    logic [`EXU_XLEN-1:0] src2;
    logic [`EXU_XLEN-1:0] imm;
    logic [`EXU_XLEN-1:0] pc;
    logic [4:0]           rd;
    logic [11:0]          csr_addr;
  } issue_t;

  typedef struct packed {
    logic                 is_load;
    logic                 is_store;
    logic [4:0]           rd;
    logic                 rwen;
    logic [`EXU_XLEN-1:0] result;
    logic [`EXU_XLEN-1:0] addr;
    logic [`EXU_XLEN-1:0] store_data;
  } exec_t;

endpackage

`default_nettype wire

// ==== design/exu_stage_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// valid/ready link between pipeline stages
interface exu_stage_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  payload_t payload;

  // producer side
  modport src (
    output valid,
    output payload,
    input  ready
  );

  // consumer side
  modport dst (
    input  valid,
    input  payload,
    output ready
  );

endinterface

`default_nettype wire

// ==== design/exu_alu.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exu_config.svh"

module exu_alu (
  input  logic [`EXU_XLEN-1:0] a_i,
  input  logic [`EXU_XLEN-1:0] b_i,
  input  exu_pkg::alu_op_t     op_i,
  output logic [`EXU_XLEN-1:0] res_o
);

  logic [5:0] shamt;

  assign shamt = b_i[5:0];

  always_comb begin
    res_o = '0;
    case (op_i)
      exu_pkg::ADD:  res_o = a_i + b_i;
      exu_pkg::SUB:  res_o = a_i - b_i;
      exu_pkg::AND:  res_o = a_i & b_i;
      exu_pkg::OR:   res_o = a_i | b_i;
      exu_pkg::XOR:  res_o = a_i ^ b_i;
      exu_pkg::SLL:  res_o = a_i << shamt;
      exu_pkg::SRL:  res_o = a_i >> shamt;
      exu_pkg::SRA:  res_o = $signed(a_i) >>> shamt;
      // compares leave a single bit in res_o[0]
      exu_pkg::SLT:  res_o[0] = $signed(a_i) < $signed(b_i);
      exu_pkg::SLTU: res_o[0] = a_i < b_i;
      exu_pkg::SGE:  res_o[0] = $signed(a_i) >= $signed(b_i);
      exu_pkg::SGEU: res_o[0] = a_i >= b_i;
      default:       res_o = '0;
    endcase
  end

  // no clock here, so checked whenever the inputs settle
  always_comb begin
    if (!$isunknown({a_i, b_i, op_i})) begin
      assert (!$isunknown(res_o))
        else $error("alu result unknown for op %0d", op_i);
    end
  end

endmodule

`default_nettype wire

// ==== design/exu_csr_file.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exu_config.svh"

module exu_csr_file (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wen_i,
  input  logic [11:0]          addr_i,
  input  logic [`EXU_XLEN-1:0] wdata_i,
  input  logic                 trap_i,
  input  logic [`EXU_XLEN-1:0] trap_pc_i,
  output logic [`EXU_XLEN-1:0] rdata_o,
  output logic [`EXU_XLEN-1:0] mepc_o,
  output logic [`EXU_XLEN-1:0] mtvec_o
);

  logic [`EXU_XLEN-1:0] mepc;
  logic [`EXU_XLEN-1:0] mtvec;
  logic [`EXU_XLEN-1:0] mcause;
  logic [`EXU_XLEN-1:0] mscratch;

  always_comb begin
    case (addr_i)
      `EXU_CSR_MEPC:     rdata_o = mepc;
      `EXU_CSR_MTVEC:    rdata_o = mtvec;
      `EXU_CSR_MCAUSE:   rdata_o = mcause;
      `EXU_CSR_MSCRATCH: rdata_o = mscratch;
      default:           rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mepc     <= '0;
      mtvec    <= '0;
      mcause   <= '0;
      mscratch <= '0;
    end else if (trap_i) begin
      mepc   <= trap_pc_i;
      mcause <= `EXU_XLEN'(`EXU_CAUSE_ECALL);
    end else if (wen_i) begin
      case (addr_i)
        `EXU_CSR_MEPC:     mepc     <= wdata_i;
        `EXU_CSR_MTVEC:    mtvec    <= wdata_i;
        `EXU_CSR_MCAUSE:   mcause   <= wdata_i;
        `EXU_CSR_MSCRATCH: mscratch <= wdata_i;
        default:           ;
      endcase
    end
  end

  assign mepc_o  = mepc;
  assign mtvec_o = mtvec;

  // execute never issues a csr op and an ecall in one acceptance
  a_no_trap_and_write: assert property (
    @(posedge clk) disable iff (rst) !(trap_i && wen_i)
  ) else $error("csr trap and write in the same cycle");

endmodule

`default_nettype wire

// ==== design/exu_execute.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exu_config.svh"

module exu_execute (
  input  logic                 clk,
  input  logic                 rst,
  exu_stage_if.dst             in,
  exu_stage_if.src             out,
  output logic                 redirect_valid_o,
  output logic [`EXU_XLEN-1:0] redirect_pc_o,
  output logic                 ebreak_o
);

  exu_pkg::issue_t      iss;
  exu_pkg::exec_t       exec_d;
  exu_pkg::exec_t       exec_q;
  logic                 accept;
  logic                 out_valid;
  logic [`EXU_XLEN-1:0] alu_res;
  logic [`EXU_XLEN-1:0] csr_rdata;
  logic [`EXU_XLEN-1:0] csr_wdata;
  logic [`EXU_XLEN-1:0] mepc;
  logic [`EXU_XLEN-1:0] mtvec;
  logic [`EXU_XLEN-1:0] pc_imm;
  logic [`EXU_XLEN-1:0] src1_imm;
  logic [`EXU_XLEN-1:0] target;
  logic                 is_csr;
  logic                 taken;
  logic                 redirect;

  assign iss       = in.payload;
  assign in.ready  = !out_valid || out.ready;
  assign accept    = in.valid && in.ready;
  assign out.valid = out_valid;
  assign out.payload = exec_q;

  assign pc_imm   = iss.pc + iss.imm;
  assign src1_imm = iss.src1 + iss.imm;
  assign is_csr   = iss.op inside {exu_pkg::OP_CSRRW, exu_pkg::OP_CSRRS, exu_pkg::OP_CSRRC};

  exu_alu u_alu (
    .a_i   (iss.src1),
    .b_i   (iss.src2),
    .op_i  (iss.alu_op),
    .res_o (alu_res)
  );

  // csr state changes on the acceptance edge
  exu_csr_file u_csr (
    .clk       (clk),
    .rst       (rst),
    .wen_i     (accept && is_csr),
    .addr_i    (iss.csr_addr),
    .wdata_i   (csr_wdata),
    .trap_i    (accept && (iss.op == exu_pkg::OP_ECALL)),
    .trap_pc_i (iss.pc),
    .rdata_o   (csr_rdata),
    .mepc_o    (mepc),
    .mtvec_o   (mtvec)
  );

  always_comb begin
    case (iss.op)
      exu_pkg::OP_CSRRS: csr_wdata = csr_rdata | iss.src1;
      exu_pkg::OP_CSRRC: csr_wdata = csr_rdata & ~iss.src1;
      default:           csr_wdata = iss.src1;
    endcase
  end

  // beq compares with SUB, so zero means taken
  assign taken = (iss.alu_op == exu_pkg::SUB) ? (alu_res == '0) : (alu_res != '0);

  always_comb begin
    redirect = 1'b0;
    target   = pc_imm;
    case (iss.op)
      exu_pkg::OP_BRANCH: redirect = taken;
      exu_pkg::OP_JAL:    redirect = 1'b1;
      exu_pkg::OP_JALR: begin
        redirect = 1'b1;
        target   = {src1_imm[`EXU_XLEN-1:1], 1'b0};
      end
      exu_pkg::OP_ECALL: begin
        redirect = 1'b1;
        target   = mtvec;
      end
      exu_pkg::OP_MRET: begin
        redirect = 1'b1;
        target   = mepc;
      end
      default: ;
    endcase
  end

  always_comb begin
    exec_d.is_load    = iss.op == exu_pkg::OP_LOAD;
    exec_d.is_store   = iss.op == exu_pkg::OP_STORE;
    exec_d.rd         = iss.rd;
    exec_d.rwen       = (iss.rd != 5'd0) && (is_csr || iss.op inside {exu_pkg::OP_ALU,
                        exu_pkg::OP_JAL, exu_pkg::OP_JALR, exu_pkg::OP_LOAD});
    exec_d.addr       = src1_imm;
    exec_d.store_data = iss.src2;
    case (iss.op)
      exu_pkg::OP_ALU:  exec_d.result = alu_res;
      exu_pkg::OP_JAL:  exec_d.result = iss.pc + `EXU_XLEN'(4);
      exu_pkg::OP_JALR: exec_d.result = iss.pc + `EXU_XLEN'(4);
      default:          exec_d.result = is_csr ? csr_rdata : '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid        <= 1'b0;
      redirect_valid_o <= 1'b0;
      ebreak_o         <= 1'b0;
    end else begin
      if (accept) begin
        out_valid <= 1'b1;
      end else if (out.ready) begin
        out_valid <= 1'b0;
      end
      // single-cycle pulses
      redirect_valid_o <= accept && redirect;
      ebreak_o         <= accept && (iss.op == exu_pkg::OP_EBREAK);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      exec_q        <= exec_d;
      redirect_pc_o <= target;
    end
  end

  a_redirect_after_accept: assert property (
    @(posedge clk) disable iff (rst) redirect_valid_o |-> $past(accept)
  ) else $error("redirect without a preceding acceptance");

endmodule

`default_nettype wire

// ==== design/exu_mem_stage.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exu_config.svh"

module exu_mem_stage (
  input  logic                 clk,
  input  logic                 rst,
  exu_stage_if.dst             in,
  output logic                 bus_avalid_o,
  output logic                 bus_wen_o,
  output logic [`EXU_XLEN-1:0] bus_addr_o,
  output logic [`EXU_XLEN-1:0] bus_wdata_o,
  input  logic [`EXU_XLEN-1:0] bus_rdata_i,
  input  logic                 bus_rvalid_i,
  input  logic                 bus_wready_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [4:0]           out_rd_o,
  output logic                 out_rwen_o,
  output logic [`EXU_XLEN-1:0] out_wdata_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BUS,
    ST_DONE
  } state_t;

  state_t               state;
  exu_pkg::exec_t       item;
  logic [`EXU_XLEN-1:0] wb_data;
  logic                 accept;
  logic                 bus_done;

  // a finishing item makes room in the same cycle
  assign in.ready = (state == ST_IDLE) || ((state == ST_DONE) && out_ready_i);
  assign accept   = in.valid && in.ready;
  assign bus_done = (state == ST_BUS) && (item.is_store ? bus_wready_i : bus_rvalid_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_BUS:  if (bus_done) state <= ST_DONE;
        ST_DONE: if (out_ready_i) state <= ST_IDLE;
        default: ;
      endcase
      if (accept) begin
        state <= (in.payload.is_load || in.payload.is_store) ? ST_BUS : ST_DONE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      item    <= in.payload;
      wb_data <= in.payload.result;
    end else if (bus_done && item.is_load) begin
      wb_data <= bus_rdata_i;
    end
  end

  assign bus_avalid_o = state == ST_BUS;
  assign bus_wen_o    = item.is_store;
  assign bus_addr_o   = item.addr;
  assign bus_wdata_o  = item.store_data;

  assign out_valid_o = state == ST_DONE;
  assign out_rd_o    = item.rd;
  assign out_rwen_o  = item.rwen;
  assign out_wdata_o = wb_data;

  a_avalid_held: assert property (
    @(posedge clk) disable iff (rst) bus_avalid_o && !bus_done |=> bus_avalid_o
  ) else $error("bus request dropped before response");

  a_out_stable: assert property (
    @(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_rd_o)
      && $stable(out_rwen_o) && $stable(out_wdata_o)
  ) else $error("writeback changed under back-pressure");

endmodule

`default_nettype wire

// ==== design/exu_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exu_config.svh"

module exu_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  exu_pkg::op_class_t   in_op_i,
  input  exu_pkg::alu_op_t     in_alu_op_i,
  input  logic [`EXU_XLEN-1:0] in_src1_i,
  input  logic [`EXU_XLEN-1:0] in_src2_i,
  input  logic [`EXU_XLEN-1:0] in_imm_i,
  input  logic [`EXU_XLEN-1:0] in_pc_i,
  input  logic [4:0]           in_rd_i,
  input  logic [11:0]          in_csr_addr_i,
  output logic                 redirect_valid_o,
  output logic [`EXU_XLEN-1:0] redirect_pc_o,
  output logic                 ebreak_o,
  output logic                 bus_avalid_o,
  output logic                 bus_wen_o,
  output logic [`EXU_XLEN-1:0] bus_addr_o,
  output logic [`EXU_XLEN-1:0] bus_wdata_o,
  input  logic [`EXU_XLEN-1:0] bus_rdata_i,
  input  logic                 bus_rvalid_i,
  input  logic                 bus_wready_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [4:0]           out_rd_o,
  output logic                 out_rwen_o,
  output logic [`EXU_XLEN-1:0] out_wdata_o
);

  exu_stage_if #(.payload_t(exu_pkg::issue_t)) issue_if ();
  exu_stage_if #(.payload_t(exu_pkg::exec_t))  exec_if ();

  assign issue_if.valid   = in_valid_i;
  assign in_ready_o       = issue_if.ready;
  assign issue_if.payload = '{
    op:       in_op_i,
    alu_op:   in_alu_op_i,
    src1:     in_src1_i,
    src2:     in_src2_i,
    imm:      in_imm_i,
    pc:       in_pc_i,
    rd:       in_rd_i,
    csr_addr: in_csr_addr_i
  };

  exu_execute u_execute (
    .clk              (clk),
    .rst              (rst),
    .in               (issue_if.dst),
    .out              (exec_if.src),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o),
    .ebreak_o         (ebreak_o)
  );

  exu_mem_stage u_mem (
    .clk          (clk),
    .rst          (rst),
    .in           (exec_if.dst),
    .bus_avalid_o (bus_avalid_o),
    .bus_wen_o    (bus_wen_o),
    .bus_addr_o   (bus_addr_o),
    .bus_wdata_o  (bus_wdata_o),
    .bus_rdata_i  (bus_rdata_i),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_wready_i (bus_wready_i),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .out_rd_o     (out_rd_o),
    .out_rwen_o   (out_rwen_o),
    .out_wdata_o  (out_wdata_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_exu.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "exu_config.svh"

module tb_exu;

  localparam int NUM_INSTR = 300;
  localparam int MAX_CYCLES = 16 + NUM_INSTR * 8;

  logic clk, rst, in_valid_i, in_ready_o;
  exu_pkg::op_class_t in_op_i;
  exu_pkg::alu_op_t in_alu_op_i;
  logic [`EXU_XLEN-1:0] in_src1_i, in_src2_i, in_imm_i, in_pc_i;
  logic [4:0] in_rd_i;
  logic [11:0] in_csr_addr_i;
  logic redirect_valid_o, ebreak_o, bus_avalid_o, bus_wen_o;
  logic [`EXU_XLEN-1:0] redirect_pc_o, bus_addr_o, bus_wdata_o;
  logic [`EXU_XLEN-1:0] bus_rdata_i = '0;
  logic bus_rvalid_i = 1'b0, bus_wready_i = 1'b0, out_ready_i = 1'b0;
  logic out_valid_o, out_rwen_o;
  logic [4:0] out_rd_o;
  logic [`EXU_XLEN-1:0] out_wdata_o;

  integer seed = 32'hcdc01cfa;
  integer cycles = 0;
  integer issued = 0;
  integer wr_ptr = 0;
  integer rd_ptr = 0;
  logic [63:0] mem [0:255];
  logic [63:0] ref_mem [0:255];
  logic [4:0] exp_rd [0:511];
  logic exp_rwen [0:511];
  logic [63:0] exp_wdata [0:511];
  logic [4:0] head_rd;
  logic head_rwen;
  logic [63:0] head_wdata;
  logic exp_redir = 1'b0;
  logic exp_ebreak = 1'b0;
  logic [63:0] exp_redir_pc = '0;
  logic [63:0] csr_mepc = '0, csr_mtvec = '0, csr_mcause = '0, csr_mscratch = '0;
  logic [1:0] bus_delay;

  exu_top u_dut (.*);

  assign head_rd    = exp_rd[rd_ptr[8:0]];
  assign head_rwen  = exp_rwen[rd_ptr[8:0]];
  assign head_wdata = exp_wdata[rd_ptr[8:0]];

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_fail();
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic mismatch(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
    $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
    stop_fail();
  endtask

  function automatic logic [63:0] alu_ref(exu_pkg::alu_op_t op, logic [63:0] a, logic [63:0] b);
    case (op)
      exu_pkg::ADD:  return a + b;
      exu_pkg::SUB:  return a - b;
      exu_pkg::AND:  return a & b;
      exu_pkg::OR:   return a | b;
      exu_pkg::XOR:  return a ^ b;
      exu_pkg::SLL:  return a << b[5:0];
      exu_pkg::SRL:  return a >> b[5:0];
      exu_pkg::SRA:  return $signed(a) >>> b[5:0];
      exu_pkg::SLT:  return {63'd0, $signed(a) < $signed(b)};
      exu_pkg::SLTU: return {63'd0, a < b};
      exu_pkg::SGE:  return {63'd0, $signed(a) >= $signed(b)};
      exu_pkg::SGEU: return {63'd0, a >= b};
      default:       return '0;
    endcase
  endfunction

  function automatic logic [63:0] csr_read(logic [11:0] addr);
    case (addr)
      `EXU_CSR_MEPC:     return csr_mepc;
      `EXU_CSR_MTVEC:    return csr_mtvec;
      `EXU_CSR_MCAUSE:   return csr_mcause;
      `EXU_CSR_MSCRATCH: return csr_mscratch;
      default:           return '0;
    endcase
  endfunction

  // random instruction; memory ops stay inside a 32 word window so loads hit stores
  task automatic drive_instr();
    logic [31:0] r;
    logic [63:0] src2;
    logic [11:0] csr_sel [0:4];
    exu_pkg::op_class_t op;
    csr_sel = '{`EXU_CSR_MEPC, `EXU_CSR_MTVEC, `EXU_CSR_MCAUSE, `EXU_CSR_MSCRATCH, 12'h7c0};
    r = $random(seed);
    case (r[3:0])
      4'd0, 4'd1, 4'd2, 4'd3: op = exu_pkg::OP_ALU;
      4'd4:  op = exu_pkg::OP_BRANCH;
      4'd5:  op = exu_pkg::OP_JAL;
      4'd6:  op = exu_pkg::OP_JALR;
      4'd7, 4'd8:  op = exu_pkg::OP_LOAD;
      4'd9, 4'd10: op = exu_pkg::OP_STORE;
      4'd11: op = exu_pkg::OP_CSRRW;
      4'd12: op = exu_pkg::OP_CSRRS;
      4'd13: op = exu_pkg::OP_CSRRC;
      4'd14: op = r[4] ? exu_pkg::OP_ECALL : exu_pkg::OP_MRET;
      default: op = exu_pkg::OP_EBREAK;
    endcase
    src2 = r[5] ? {$random(seed), $random(seed)} : {60'd0, r[9:6]};
    in_valid_i    <= 1'b1;
    in_op_i       <= op;
    in_alu_op_i   <= exu_pkg::alu_op_t'({$random(seed)} % 12);
    in_src2_i     <= src2;
    in_pc_i       <= {$random(seed), $random(seed)} & ~64'd3;
    in_rd_i       <= r[14:10];
    in_csr_addr_i <= csr_sel[{$random(seed)} % 5];
    if (op inside {exu_pkg::OP_LOAD, exu_pkg::OP_STORE}) begin
      in_src1_i <= {56'd0, r[20:16], 3'd0};
      in_imm_i  <= {60'd0, r[21], 3'd0};
    end else begin
      in_src1_i <= r[22] ? {$random(seed), $random(seed)} : src2;
      in_imm_i  <= {{52{r[23]}}, r[31:24], 4'd0};
    end
  endtask

  // reference model, applied at the acceptance edge in issue order
  task automatic model_issue();
    logic [63:0] wb, tgt, maddr, old_v, new_v;
    logic redir, rw;
    wb    = '0;
    redir = 1'b0;
    tgt   = in_pc_i + in_imm_i;
    maddr = in_src1_i + in_imm_i;
    rw    = (in_rd_i != 5'd0) && (in_op_i inside {exu_pkg::OP_ALU, exu_pkg::OP_JAL,
            exu_pkg::OP_JALR, exu_pkg::OP_LOAD, exu_pkg::OP_CSRRW, exu_pkg::OP_CSRRS,
            exu_pkg::OP_CSRRC});
    case (in_op_i)
      exu_pkg::OP_ALU: wb = alu_ref(in_alu_op_i, in_src1_i, in_src2_i);
      exu_pkg::OP_BRANCH: redir = (in_alu_op_i == exu_pkg::SUB) ? (in_src1_i == in_src2_i)
                                  : (alu_ref(in_alu_op_i, in_src1_i, in_src2_i) != '0);
      exu_pkg::OP_JAL: begin
        redir = 1'b1;
        wb    = in_pc_i + 64'd4;
      end
      exu_pkg::OP_JALR: begin
        redir = 1'b1;
        wb    = in_pc_i + 64'd4;
        tgt   = maddr & ~64'd1;
      end
      exu_pkg::OP_LOAD:  wb = ref_mem[maddr[10:3]];
      exu_pkg::OP_STORE: ref_mem[maddr[10:3]] = in_src2_i;
      exu_pkg::OP_CSRRW, exu_pkg::OP_CSRRS, exu_pkg::OP_CSRRC: begin
        old_v = csr_read(in_csr_addr_i);
        wb    = old_v;
        if (in_op_i == exu_pkg::OP_CSRRW) new_v = in_src1_i;
        else if (in_op_i == exu_pkg::OP_CSRRS) new_v = old_v | in_src1_i;
        else new_v = old_v & ~in_src1_i;
        case (in_csr_addr_i)
          `EXU_CSR_MEPC:     csr_mepc = new_v;
          `EXU_CSR_MTVEC:    csr_mtvec = new_v;
          `EXU_CSR_MCAUSE:   csr_mcause = new_v;
          `EXU_CSR_MSCRATCH: csr_mscratch = new_v;
          default: ;
        endcase
      end
      exu_pkg::OP_ECALL: begin
        redir      = 1'b1;
        tgt        = csr_mtvec;
        csr_mepc   = in_pc_i;
        csr_mcause = 64'd`EXU_CAUSE_ECALL;
      end
      exu_pkg::OP_MRET: begin
        redir = 1'b1;
        tgt   = csr_mepc;
      end
      exu_pkg::OP_EBREAK: exp_ebreak <= 1'b1;
      default: ;
    endcase
    exp_redir             <= redir;
    exp_redir_pc          <= tgt;
    exp_rd[wr_ptr[8:0]]    <= in_rd_i;
    exp_rwen[wr_ptr[8:0]]  <= rw;
    exp_wdata[wr_ptr[8:0]] <= wb;
    wr_ptr                <= wr_ptr + 1;
  endtask

  initial begin
    rst = 1'b1;
    in_valid_i = 1'b0;
    in_op_i = exu_pkg::OP_ALU;
    in_alu_op_i = exu_pkg::ADD;
    {in_src1_i, in_src2_i, in_imm_i, in_pc_i} = '0;
    in_rd_i = '0;
    in_csr_addr_i = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i]     = {24'hd00d00, i[7:0], 24'h5a5a5a, ~i[7:0]};
      ref_mem[i] = mem[i];
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    drive_instr();
    while (issued < NUM_INSTR) begin
      @(posedge clk);
      exp_redir  <= 1'b0;
      exp_ebreak <= 1'b0;
      if (in_valid_i && in_ready_o) begin
        model_issue();
        issued = issued + 1;
        if (issued < NUM_INSTR) drive_instr();
        else in_valid_i <= 1'b0;
      end
    end
    // last pulse expectation ends one cycle after the final acceptance
    @(posedge clk);
    exp_redir  <= 1'b0;
    exp_ebreak <= 1'b0;
    while (rd_ptr != wr_ptr) @(posedge clk);
    repeat (4) @(posedge clk);
    if (rd_ptr == wr_ptr && !out_valid_o && !bus_avalid_o) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("extra activity after the last expected result");
      stop_fail();
    end
  end

  // bus responder with 0 to 3 extra wait cycles
  always @(posedge clk) begin
    if (rst) begin
      bus_rvalid_i <= 1'b0;
      bus_wready_i <= 1'b0;
      bus_rdata_i  <= '0;
      bus_delay    <= 2'd0;
    end else begin
      bus_rvalid_i <= 1'b0;
      bus_wready_i <= 1'b0;
      if (bus_rvalid_i || bus_wready_i) begin
        bus_delay <= 2'({$random(seed)} % 4);
      end else if (bus_avalid_o && bus_delay != 2'd0) begin
        bus_delay <= bus_delay - 2'd1;
      end else if (bus_avalid_o && bus_wen_o) begin
        mem[bus_addr_o[10:3]] <= bus_wdata_o;
        bus_wready_i <= 1'b1;
      end else if (bus_avalid_o) begin
        bus_rdata_i  <= mem[bus_addr_o[10:3]];
        bus_rvalid_i <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    out_ready_i <= rst ? 1'b0 : ({$random(seed)} % 3 != 0);
    if (!rst && out_valid_o && out_ready_i) rd_ptr <= rd_ptr + 1;
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d instructions issued", cycles, issued);
      stop_fail();
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    $fell(rst) |-> !out_valid_o && !bus_avalid_o && !redirect_valid_o && !ebreak_o)
    else begin
      $display("outputs active right after reset");
      stop_fail();
    end

  a_redirect: assert property (@(posedge clk) disable iff (rst) redirect_valid_o == exp_redir)
    else mismatch("redirect_valid_o", $sampled(exp_redir), $sampled(redirect_valid_o));

  a_redirect_pc: assert property (@(posedge clk) disable iff (rst)
    redirect_valid_o |-> redirect_pc_o == exp_redir_pc)
    else mismatch("redirect_pc_o", $sampled(exp_redir_pc), $sampled(redirect_pc_o));

  a_ebreak: assert property (@(posedge clk) disable iff (rst) ebreak_o == exp_ebreak)
    else mismatch("ebreak_o", $sampled(exp_ebreak), $sampled(ebreak_o));

  a_no_extra: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && out_ready_i |-> rd_ptr != wr_ptr)
    else begin
      $display("writeback seen with no instruction outstanding");
      stop_fail();
    end

  a_out_rd: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && out_ready_i |-> out_rd_o == head_rd)
    else mismatch("out_rd_o", $sampled(head_rd), $sampled(out_rd_o));

  a_out_rwen: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && out_ready_i |-> out_rwen_o == head_rwen)
    else mismatch("out_rwen_o", $sampled(head_rwen), $sampled(out_rwen_o));

  a_out_wdata: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && out_ready_i && head_rwen |-> out_wdata_o == head_wdata)
    else mismatch("out_wdata_o", $sampled(head_wdata), $sampled(out_wdata_o));

  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_rd_o) && $stable(out_rwen_o)
      && $stable(out_wdata_o))
    else begin
      $display("writeback outputs changed while stalled");
      stop_fail();
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+design
design/exu_pkg.sv
design/exu_stage_if.sv
design/exu_alu.sv
design/exu_csr_file.sv
design/exu_execute.sv
design/exu_mem_stage.sv
design/exu_top.sv
testbench/tb_exu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute back end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
  -f all.f --top-module tb_exu -o tb_exu

out=$(./obj_dir/tb_exu || true)
echo "$out"
echo "$out" | grep -qx ">>> PASS"
